// File: rtl/mesh_dir_pkg.sv
// ====================
// mesh direction package
// router port order, port count and tile coordinate types
// ====================

package mesh_dir_pkg;

  // router ports, local processor first
  typedef enum logic [2:0] {
    P = 3'd0,
    W = 3'd1,
    E = 3'd2,
    N = 3'd3,
    S = 3'd4
  } dir_e;

  localparam int num_dirs_c = 5;

  // tile coordinates within the mesh
  typedef logic [3:0] x_cord_t;
  typedef logic [3:0] y_cord_t;

endpackage

// File: rtl/manycore_packet_pkg.sv
// ====================
// manycore packet package
// request and return packets and the link bundles that carry them
// ====================

package manycore_packet_pkg;

  typedef logic [31:0] data_t;
  typedef logic [15:0] addr_t;

  // destination fields sit in the top bits, the router reads only those
  typedef struct packed {
    mesh_dir_pkg::x_cord_t dest_x;
    mesh_dir_pkg::y_cord_t dest_y;
    mesh_dir_pkg::x_cord_t src_x;
    mesh_dir_pkg::y_cord_t src_y;
    addr_t                 addr;
    data_t                 data;
  } fwd_packet_s;

  typedef struct packed {
    mesh_dir_pkg::x_cord_t dest_x;
    mesh_dir_pkg::y_cord_t dest_y;
    data_t                 data;
  } rev_packet_s;

  // ready_and_rev runs against v, it belongs to the partner's outgoing link
  typedef struct packed {
    logic        v;
    fwd_packet_s packet;
    logic        ready_and_rev;
  } fwd_link_s;

  typedef struct packed {
    logic        v;
    rev_packet_s packet;
    logic        ready_and_rev;
  } rev_link_s;

  // one bundle per node port
  typedef struct packed {
    fwd_link_s fwd;
    rev_link_s rev;
  } link_sif_s;

endpackage

// File: rtl/router_input_fifo.sv
// ====================
// router input buffer
// circular FIFO holding packets until they win an output
// ====================
`timescale 1ns/1ps

module router_input_fifo #(
  parameter int width_p = 64,
  parameter int els_p   = 2
) (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic               v_i,
  input  logic [width_p-1:0] data_i,
  output logic               ready_o,
  output logic               v_o,
  output logic [width_p-1:0] data_o,
  input  logic               yumi_i
);

  localparam int ptr_w_lp = (els_p > 1) ? $clog2(els_p) : 1;
  localparam int cnt_w_lp = $clog2(els_p + 1);

  typedef logic [ptr_w_lp-1:0] ptr_t;
  typedef logic [cnt_w_lp-1:0] cnt_t;

  logic [width_p-1:0] mem_r [els_p];
  ptr_t rptr_r;
  ptr_t wptr_r;
  cnt_t count_r;
  logic push;
  logic pop;

  // wrap at els_p so any depth works
  function automatic ptr_t next_ptr(ptr_t p);
    if (p == ptr_t'(els_p - 1)) begin
      return '0;
    end
    return p + ptr_t'(1);
  endfunction

  // ready only reflects fill level, never the incoming valid
  assign ready_o = (count_r != cnt_t'(els_p));
  assign v_o     = (count_r != '0);
  assign data_o  = mem_r[rptr_r];
  assign push    = v_i & ready_o;
  assign pop     = yumi_i & v_o;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_r[wptr_r] <= data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rptr_r  <= '0;
      wptr_r  <= '0;
      count_r <= '0;
    end else begin
      if (push) begin
        wptr_r <= next_ptr(wptr_r);
      end
      if (pop) begin
        rptr_r <= next_ptr(rptr_r);
      end
      if (push && !pop) begin
        count_r <= count_r + cnt_t'(1);
      end else if (pop && !push) begin
        count_r <= count_r - cnt_t'(1);
      end
    end
  end

endmodule

// File: rtl/router_route_decode.sv
// ====================
// route decode
// dimension-ordered output choice for one head packet
// ====================
`timescale 1ns/1ps

module router_route_decode #(
  parameter bit xy_order_p = 1'b1
) (
  input  logic                                v_i,
  input  mesh_dir_pkg::x_cord_t               dest_x_i,
  input  mesh_dir_pkg::y_cord_t               dest_y_i,
  input  mesh_dir_pkg::x_cord_t               my_x_i,
  input  mesh_dir_pkg::y_cord_t               my_y_i,
  output logic [mesh_dir_pkg::num_dirs_c-1:0] req_o
);

  logic x_lt;
  logic x_gt;
  logic y_lt;
  logic y_gt;

  assign x_lt = (dest_x_i < my_x_i);
  assign x_gt = (dest_x_i > my_x_i);
  assign y_lt = (dest_y_i < my_y_i);
  assign y_gt = (dest_y_i > my_y_i);

  // one-hot request, P once both coordinates match
  always_comb begin
    req_o = '0;
    if (v_i) begin
      if (xy_order_p) begin
        if (x_lt)      req_o[mesh_dir_pkg::W] = 1'b1;
        else if (x_gt) req_o[mesh_dir_pkg::E] = 1'b1;
        else if (y_lt) req_o[mesh_dir_pkg::N] = 1'b1;
        else if (y_gt) req_o[mesh_dir_pkg::S] = 1'b1;
        else           req_o[mesh_dir_pkg::P] = 1'b1;
      end else begin
        if (y_lt)      req_o[mesh_dir_pkg::N] = 1'b1;
        else if (y_gt) req_o[mesh_dir_pkg::S] = 1'b1;
        else if (x_lt) req_o[mesh_dir_pkg::W] = 1'b1;
        else if (x_gt) req_o[mesh_dir_pkg::E] = 1'b1;
        else           req_o[mesh_dir_pkg::P] = 1'b1;
      end
    end
  end

endmodule

// File: rtl/router_output_arbiter.sv
// ====================
// output arbiter
// round-robin choice among inputs requesting one output
// ====================
`timescale 1ns/1ps

module router_output_arbiter (
  input  logic                                clk_i,
  input  logic                                rst_i,
  input  logic [mesh_dir_pkg::num_dirs_c-1:0] req_i,
  input  logic                                ready_i,
  output logic [mesh_dir_pkg::num_dirs_c-1:0] grant_o,
  output logic                                v_o
);

  localparam int dirs_lp  = mesh_dir_pkg::num_dirs_c;
  localparam int idx_w_lp = $clog2(dirs_lp);

  typedef logic [idx_w_lp-1:0] idx_t;

  idx_t last_r;
  idx_t rr_idx;
  idx_t sel_idx;
  idx_t hold_idx_r;
  logic hold_r;

  // nearest requester after the last winner, scanned from far to near
  always_comb begin
    idx_t cand;
    rr_idx = last_r;
    for (int i = dirs_lp; i >= 1; i--) begin
      cand = idx_t'((int'(last_r) + i) % dirs_lp);
      if (req_i[cand]) begin
        rr_idx = cand;
      end
    end
  end

  // a stalled output keeps its winner so the packet stays stable
  assign sel_idx = hold_r ? hold_idx_r : rr_idx;
  assign v_o     = |req_i;

  always_comb begin
    grant_o          = '0;
    grant_o[sel_idx] = v_o;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      last_r <= idx_t'(dirs_lp - 1);
      hold_r <= 1'b0;
    end else begin
      hold_r <= v_o & ~ready_i;
      // pointer moves only on a completed transfer
      if (v_o && ready_i) begin
        last_r <= sel_idx;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    hold_idx_r <= sel_idx;
  end

endmodule

// File: rtl/mesh_router_buffered.sv
// ====================
// buffered mesh router
// five-port router with input FIFOs, route decode and RR crossbar
// ====================
`timescale 1ns/1ps

module mesh_router_buffered #(
  parameter int width_p    = 64,
  parameter int fifo_els_p = 2,
  parameter bit xy_order_p = 1'b1
) (
  input  logic                                              clk_i,
  input  logic                                              rst_i,
  input  logic [mesh_dir_pkg::num_dirs_c-1:0]               v_i,
  input  logic [mesh_dir_pkg::num_dirs_c-1:0][width_p-1:0]  data_i,
  output logic [mesh_dir_pkg::num_dirs_c-1:0]               ready_o,
  output logic [mesh_dir_pkg::num_dirs_c-1:0]               v_o,
  output logic [mesh_dir_pkg::num_dirs_c-1:0][width_p-1:0]  data_o,
  input  logic [mesh_dir_pkg::num_dirs_c-1:0]               ready_i,
  input  mesh_dir_pkg::x_cord_t                             my_x_i,
  input  mesh_dir_pkg::y_cord_t                             my_y_i
);

  localparam int dirs_lp = mesh_dir_pkg::num_dirs_c;
  localparam int x_w_lp  = $bits(mesh_dir_pkg::x_cord_t);
  localparam int y_w_lp  = $bits(mesh_dir_pkg::y_cord_t);

  logic [dirs_lp-1:0]              fifo_v;
  logic [dirs_lp-1:0][width_p-1:0] fifo_data;
  logic [dirs_lp-1:0]              yumi;
  // req is indexed [input][output], req_t and grant are [output][input]
  logic [dirs_lp-1:0][dirs_lp-1:0] req;
  logic [dirs_lp-1:0][dirs_lp-1:0] req_t;
  logic [dirs_lp-1:0][dirs_lp-1:0] grant;

  for (genvar i = 0; i < dirs_lp; i++) begin : g_in
    router_input_fifo #(
      .width_p(width_p),
      .els_p  (fifo_els_p)
    ) fifo (
      .clk_i  (clk_i),
      .rst_i  (rst_i),
      .v_i    (v_i[i]),
      .data_i (data_i[i]),
      .ready_o(ready_o[i]),
      .v_o    (fifo_v[i]),
      .data_o (fifo_data[i]),
      .yumi_i (yumi[i])
    );

    // destination lives in the top bits of the head packet
    router_route_decode #(
      .xy_order_p(xy_order_p)
    ) decode (
      .v_i     (fifo_v[i]),
      .dest_x_i(fifo_data[i][width_p-1 -: x_w_lp]),
      .dest_y_i(fifo_data[i][width_p-x_w_lp-1 -: y_w_lp]),
      .my_x_i  (my_x_i),
      .my_y_i  (my_y_i),
      .req_o   (req[i])
    );
  end

  for (genvar o = 0; o < dirs_lp; o++) begin : g_out
    for (genvar i = 0; i < dirs_lp; i++) begin : g_col
      assign req_t[o][i] = req[i][o];
    end

    router_output_arbiter arb (
      .clk_i  (clk_i),
      .rst_i  (rst_i),
      .req_i  (req_t[o]),
      .ready_i(ready_i[o]),
      .grant_o(grant[o]),
      .v_o    (v_o[o])
    );
  end

  // and-or crossbar, pop the winner once its output takes the packet
  always_comb begin
    data_o = '0;
    yumi   = '0;
    for (int o = 0; o < dirs_lp; o++) begin
      for (int i = 0; i < dirs_lp; i++) begin
        data_o[o] = data_o[o] | ({width_p{grant[o][i]}} & fifo_data[i]);
        yumi[i]   = yumi[i] | (grant[o][i] & ready_i[o]);
      end
    end
  end

endmodule

// File: rtl/mesh_node.sv
// ====================
// mesh tile node
// forward (XY) and return (YX) routers on shared link bundles
// ====================
`timescale 1ns/1ps

module mesh_node #(
  parameter int fwd_fifo_els_p = 2,
  parameter int rev_fifo_els_p = 2
) (
  input  logic                                                      clk_i,
  input  logic                                                      rst_i,
  input  manycore_packet_pkg::link_sif_s [mesh_dir_pkg::num_dirs_c-2:0] links_sif_i,
  output manycore_packet_pkg::link_sif_s [mesh_dir_pkg::num_dirs_c-2:0] links_sif_o,
  input  manycore_packet_pkg::link_sif_s                            proc_link_sif_i,
  output manycore_packet_pkg::link_sif_s                            proc_link_sif_o,
  input  mesh_dir_pkg::x_cord_t                                     my_x_i,
  input  mesh_dir_pkg::y_cord_t                                     my_y_i
);

  localparam int dirs_lp      = mesh_dir_pkg::num_dirs_c;
  localparam int fwd_width_lp = $bits(manycore_packet_pkg::fwd_packet_s);
  localparam int rev_width_lp = $bits(manycore_packet_pkg::rev_packet_s);

  // per-direction view of the bundles, processor at P
  manycore_packet_pkg::link_sif_s [dirs_lp-1:0] link_in;
  manycore_packet_pkg::link_sif_s [dirs_lp-1:0] link_out;

  logic [dirs_lp-1:0]                   fwd_v_li, fwd_ready_lo, fwd_v_lo, fwd_ready_li;
  logic [dirs_lp-1:0][fwd_width_lp-1:0] fwd_data_li, fwd_data_lo;
  logic [dirs_lp-1:0]                   rev_v_li, rev_ready_lo, rev_v_lo, rev_ready_li;
  logic [dirs_lp-1:0][rev_width_lp-1:0] rev_data_li, rev_data_lo;

  assign link_in[mesh_dir_pkg::P] = proc_link_sif_i;
  assign proc_link_sif_o          = link_out[mesh_dir_pkg::P];

  for (genvar k = 1; k < dirs_lp; k++) begin : g_mesh
    assign link_in[k]       = links_sif_i[k-1];
    assign links_sif_o[k-1] = link_out[k];
  end

  for (genvar d = 0; d < dirs_lp; d++) begin : g_dir
    // ready on an input bundle belongs to our outgoing link on that side
    assign fwd_v_li[d]     = link_in[d].fwd.v;
    assign fwd_data_li[d]  = link_in[d].fwd.packet;
    assign fwd_ready_li[d] = link_in[d].fwd.ready_and_rev;
    assign rev_v_li[d]     = link_in[d].rev.v;
    assign rev_data_li[d]  = link_in[d].rev.packet;
    assign rev_ready_li[d] = link_in[d].rev.ready_and_rev;

    assign link_out[d].fwd.v             = fwd_v_lo[d];
    assign link_out[d].fwd.packet        = manycore_packet_pkg::fwd_packet_s'(fwd_data_lo[d]);
    assign link_out[d].fwd.ready_and_rev = fwd_ready_lo[d];
    assign link_out[d].rev.v             = rev_v_lo[d];
    assign link_out[d].rev.packet        = manycore_packet_pkg::rev_packet_s'(rev_data_lo[d]);
    assign link_out[d].rev.ready_and_rev = rev_ready_lo[d];
  end

  // request network
  mesh_router_buffered #(
    .width_p   (fwd_width_lp),
    .fifo_els_p(fwd_fifo_els_p),
    .xy_order_p(1'b1)
  ) fwd (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .v_i    (fwd_v_li),
    .data_i (fwd_data_li),
    .ready_o(fwd_ready_lo),
    .v_o    (fwd_v_lo),
    .data_o (fwd_data_lo),
    .ready_i(fwd_ready_li),
    .my_x_i (my_x_i),
    .my_y_i (my_y_i)
  );

  // return network, y resolved first
  mesh_router_buffered #(
    .width_p   (rev_width_lp),
    .fifo_els_p(rev_fifo_els_p),
    .xy_order_p(1'b0)
  ) rev (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .v_i    (rev_v_li),
    .data_i (rev_data_li),
    .ready_o(rev_ready_lo),
    .v_o    (rev_v_lo),
    .data_o (rev_data_lo),
    .ready_i(rev_ready_li),
    .my_x_i (my_x_i),
    .my_y_i (my_y_i)
  );

endmodule

// File: testbench/mesh_node_assertions.sv
// ====================
// mesh node assertions
// reset, routing and link hold rules on the node boundary
// ====================
`timescale 1ns/1ps

module mesh_node_assertions (
  input logic                                                         clk_i,
  input logic                                                         rst_i,
  input manycore_packet_pkg::link_sif_s [mesh_dir_pkg::num_dirs_c-1:0] link_in_i,
  input manycore_packet_pkg::link_sif_s [mesh_dir_pkg::num_dirs_c-1:0] link_out_i,
  input mesh_dir_pkg::x_cord_t                                        my_x_i,
  input mesh_dir_pkg::y_cord_t                                        my_y_i
);

  localparam int dirs_lp = mesh_dir_pkg::num_dirs_c;

  logic [dirs_lp-1:0] out_v;
  logic [dirs_lp-1:0] out_ready;

  // port a packet must take, first dimension chosen by xy_first
  function automatic int expected_port(bit xy_first, mesh_dir_pkg::x_cord_t dx,
                                       mesh_dir_pkg::y_cord_t dy);
    int xd;
    int yd;
    xd = (dx < my_x_i) ? 1 : ((dx > my_x_i) ? 2 : 0);
    yd = (dy < my_y_i) ? 3 : ((dy > my_y_i) ? 4 : 0);
    if (xy_first) begin
      return (xd != 0) ? xd : yd;
    end
    return (yd != 0) ? yd : xd;
  endfunction

  always_comb begin
    for (int d = 0; d < dirs_lp; d++) begin
      out_v[d]     = link_out_i[d].fwd.v | link_out_i[d].rev.v;
      out_ready[d] = link_out_i[d].fwd.ready_and_rev & link_out_i[d].rev.ready_and_rev;
    end
  end

  reset_outputs: assert property (@(posedge clk_i)
    ($past(rst_i) && !rst_i) |-> (out_v == '0 && out_ready == '1))
    else $error("output valid high or input not ready right after reset");

  for (genvar d = 0; d < dirs_lp; d++) begin : g_port
    fwd_route: assert property (@(posedge clk_i) disable iff (rst_i)
      link_out_i[d].fwd.v |-> (expected_port(1'b1, link_out_i[d].fwd.packet.dest_x,
                                             link_out_i[d].fwd.packet.dest_y) == d))
      else $error("forward packet left port %0d against XY order", d);

    rev_route: assert property (@(posedge clk_i) disable iff (rst_i)
      link_out_i[d].rev.v |-> (expected_port(1'b0, link_out_i[d].rev.packet.dest_x,
                                             link_out_i[d].rev.packet.dest_y) == d))
      else $error("return packet left port %0d against YX order", d);

    // stalled link keeps valid and packet until taken
    fwd_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      (link_out_i[d].fwd.v && !link_in_i[d].fwd.ready_and_rev)
      |=> (link_out_i[d].fwd.v && $stable(link_out_i[d].fwd.packet)))
      else $error("forward packet on port %0d changed while stalled", d);

    rev_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      (link_out_i[d].rev.v && !link_in_i[d].rev.ready_and_rev)
      |=> (link_out_i[d].rev.v && $stable(link_out_i[d].rev.packet)))
      else $error("return packet on port %0d changed while stalled", d);
  end

endmodule

bind mesh_node mesh_node_assertions assertions (
  .clk_i     (clk_i),
  .rst_i     (rst_i),
  .link_in_i (link_in),
  .link_out_i(link_out),
  .my_x_i    (my_x_i),
  .my_y_i    (my_y_i)
);

// File: testbench/mesh_node_tb.sv
// ====================
// mesh node testbench
// directed and random traffic on both networks against a queue scoreboard
// ====================
`timescale 1ns/1ps

module mesh_node_tb;

  localparam int dirs_c        = mesh_dir_pkg::num_dirs_c;
  localparam int my_x_c        = 5;
  localparam int my_y_c        = 5;
  localparam int send_limit_c  = 400;
  localparam int drain_limit_c = 4000;
  localparam int p_port_c      = int'(mesh_dir_pkg::P);
  localparam int w_port_c      = int'(mesh_dir_pkg::W);
  localparam int s_port_c      = int'(mesh_dir_pkg::S);
  // quadrants, both axes, the node itself, then x 6 y 3
  localparam int dest_x_c [10] = '{3, 7, 3, 7, 5, 5, 3, 7, 5, 6};
  localparam int dest_y_c [10] = '{3, 3, 7, 7, 3, 7, 5, 5, 5, 3};

  logic clk = 1'b0;
  logic rst;

  manycore_packet_pkg::link_sif_s [dirs_c-2:0] links_in;
  manycore_packet_pkg::link_sif_s [dirs_c-2:0] links_out;
  manycore_packet_pkg::link_sif_s              proc_in;
  manycore_packet_pkg::link_sif_s              proc_out;
  manycore_packet_pkg::link_sif_s              drv [dirs_c];
  manycore_packet_pkg::link_sif_s              mon [dirs_c];

  logic fwd_v [dirs_c];
  logic rev_v [dirs_c];
  logic fwd_rdy [dirs_c];
  logic rev_rdy [dirs_c];
  logic fwd_hold [dirs_c];
  manycore_packet_pkg::fwd_packet_s fwd_pkt [dirs_c];
  manycore_packet_pkg::rev_packet_s rev_pkt [dirs_c];

  // expected packets per input and output pair at index input*5+output
  manycore_packet_pkg::fwd_packet_s fwd_exp_q [dirs_c*dirs_c][$];
  manycore_packet_pkg::rev_packet_s rev_exp_q [dirs_c*dirs_c][$];
  int p_order_q [$];
  int senders;
  int seq_num;
  bit stall_en;

  always #10 clk = ~clk;

  mesh_node #(
    .fwd_fifo_els_p(2),
    .rev_fifo_els_p(2)
  ) uut (
    .clk_i          (clk),
    .rst_i          (rst),
    .links_sif_i    (links_in),
    .links_sif_o    (links_out),
    .proc_link_sif_i(proc_in),
    .proc_link_sif_o(proc_out),
    .my_x_i         (mesh_dir_pkg::x_cord_t'(my_x_c)),
    .my_y_i         (mesh_dir_pkg::y_cord_t'(my_y_c))
  );

  always_comb begin
    for (int d = 0; d < dirs_c; d++) begin
      drv[d].fwd.v             = fwd_v[d];
      drv[d].fwd.packet        = fwd_pkt[d];
      drv[d].fwd.ready_and_rev = fwd_rdy[d];
      drv[d].rev.v             = rev_v[d];
      drv[d].rev.packet        = rev_pkt[d];
      drv[d].rev.ready_and_rev = rev_rdy[d];
    end
  end

  assign proc_in = drv[0];
  assign mon[0]  = proc_out;
  for (genvar k = 1; k < dirs_c; k++) begin : g_mesh
    assign links_in[k-1] = drv[k];
    assign mon[k]        = links_out[k-1];
  end

  // dimension-ordered route model
  function automatic int route_dir(bit xy_first, int dx, int dy);
    int xd;
    int yd;
    xd = (dx < my_x_c) ? w_port_c : ((dx > my_x_c) ? int'(mesh_dir_pkg::E) : -1);
    yd = (dy < my_y_c) ? int'(mesh_dir_pkg::N) : ((dy > my_y_c) ? s_port_c : -1);
    if (xy_first && xd >= 0) begin
      return xd;
    end
    if (yd >= 0) begin
      return yd;
    end
    return (xd >= 0) ? xd : p_port_c;
  endfunction

  task automatic report_error(string msg);
    $display("ERROR at %0t: %s", $time, msg);
    $display("test failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_timeout(string what);
    $display("timeout at %0t while waiting for %s", $time, what);
    $display("test failed");
    $fatal(1, "wait limit reached");
  endtask

  // input index rides in the top data nibble
  function automatic manycore_packet_pkg::fwd_packet_s make_fwd(int in, int dx, int dy);
    manycore_packet_pkg::fwd_packet_s p;
    p.dest_x = mesh_dir_pkg::x_cord_t'(dx);
    p.dest_y = mesh_dir_pkg::y_cord_t'(dy);
    p.src_x  = mesh_dir_pkg::x_cord_t'(my_x_c);
    p.src_y  = mesh_dir_pkg::y_cord_t'(my_y_c);
    p.addr   = manycore_packet_pkg::addr_t'($urandom);
    p.data   = {4'(in), 12'(seq_num), 16'($urandom)};
    seq_num++;
    return p;
  endfunction

  function automatic manycore_packet_pkg::rev_packet_s make_rev(int in, int dx, int dy);
    manycore_packet_pkg::rev_packet_s p;
    p.dest_x = mesh_dir_pkg::x_cord_t'(dx);
    p.dest_y = mesh_dir_pkg::y_cord_t'(dy);
    p.data   = {4'(in), 12'(seq_num), 16'($urandom)};
    seq_num++;
    return p;
  endfunction

  // starts on a falling edge and returns on the falling edge after the transfer
  task automatic send_fwd(int d, manycore_packet_pkg::fwd_packet_s p);
    int waited;
    senders++;
    fwd_v[d]   = 1'b1;
    fwd_pkt[d] = p;
    waited     = 0;
    while (!mon[d].fwd.ready_and_rev && waited < send_limit_c) begin
      @(negedge clk);
      waited++;
    end
    if (!mon[d].fwd.ready_and_rev) begin
      report_timeout($sformatf("forward input %0d to accept", d));
    end
    fwd_exp_q[d*dirs_c + route_dir(1'b1, int'(p.dest_x), int'(p.dest_y))].push_back(p);
    @(negedge clk);
    fwd_v[d] = 1'b0;
    senders--;
  endtask

  task automatic send_rev(int d, manycore_packet_pkg::rev_packet_s p);
    int waited;
    senders++;
    rev_v[d]   = 1'b1;
    rev_pkt[d] = p;
    waited     = 0;
    while (!mon[d].rev.ready_and_rev && waited < send_limit_c) begin
      @(negedge clk);
      waited++;
    end
    if (!mon[d].rev.ready_and_rev) begin
      report_timeout($sformatf("return input %0d to accept", d));
    end
    rev_exp_q[d*dirs_c + route_dir(1'b0, int'(p.dest_x), int'(p.dest_y))].push_back(p);
    @(negedge clk);
    rev_v[d] = 1'b0;
    senders--;
  endtask

  // output sink for both networks with ready chosen on each falling edge
  task automatic receive(int o);
    manycore_packet_pkg::fwd_packet_s fwd_got;
    manycore_packet_pkg::rev_packet_s rev_got;
    int in;
    forever begin
      @(negedge clk);
      fwd_rdy[o] = stall_en ? ($urandom_range(0, 3) != 0) : !fwd_hold[o];
      rev_rdy[o] = stall_en ? ($urandom_range(0, 3) != 0) : 1'b1;
      if (mon[o].fwd.v && fwd_rdy[o]) begin
        fwd_got = mon[o].fwd.packet;
        in      = int'(fwd_got.data[31:28]);
        assert (in < dirs_c && fwd_exp_q[in*dirs_c+o].size() > 0)
          else report_error($sformatf("unexpected forward packet %h on port %0d", fwd_got, o));
        assert (fwd_got == fwd_exp_q[in*dirs_c+o][0])
          else report_error($sformatf("forward port %0d got %h expected %h", o, fwd_got,
                                      fwd_exp_q[in*dirs_c+o][0]));
        void'(fwd_exp_q[in*dirs_c+o].pop_front());
        if (o == p_port_c) begin
          p_order_q.push_back(in);
        end
      end
      if (mon[o].rev.v && rev_rdy[o]) begin
        rev_got = mon[o].rev.packet;
        in      = int'(rev_got.data[31:28]);
        assert (in < dirs_c && rev_exp_q[in*dirs_c+o].size() > 0)
          else report_error($sformatf("unexpected return packet %h on port %0d", rev_got, o));
        assert (rev_got == rev_exp_q[in*dirs_c+o][0])
          else report_error($sformatf("return port %0d got %h expected %h", o, rev_got,
                                      rev_exp_q[in*dirs_c+o][0]));
        void'(rev_exp_q[in*dirs_c+o].pop_front());
      end
    end
  endtask

  function automatic bit queues_empty();
    for (int i = 0; i < dirs_c*dirs_c; i++) begin
      if (fwd_exp_q[i].size() != 0 || rev_exp_q[i].size() != 0) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  task automatic wait_drain(string what);
    int waited;
    waited = 0;
    while ((!queues_empty() || senders != 0) && waited < drain_limit_c) begin
      @(negedge clk);
      waited++;
    end
    if (!queues_empty() || senders != 0) begin
      report_timeout(what);
    end
  endtask

  task automatic random_port(int d, bit rev_net, int count);
    for (int n = 0; n < count; n++) begin
      repeat ($urandom_range(0, 2)) @(negedge clk);
      if (rev_net) begin
        send_rev(d, make_rev(d, $urandom_range(0, 15), $urandom_range(0, 15)));
      end else begin
        send_fwd(d, make_fwd(d, $urandom_range(0, 15), $urandom_range(0, 15)));
      end
    end
  endtask

  initial begin
    manycore_packet_pkg::fwd_packet_s held;
    int order_mask;
    void'($urandom(32'hfaa6_3a9f));
    rst      = 1'b1;
    stall_en = 1'b0;
    senders  = 0;
    seq_num  = 0;
    for (int d = 0; d < dirs_c; d++) begin
      fwd_v[d]    = 1'b0;
      rev_v[d]    = 1'b0;
      fwd_rdy[d]  = 1'b1;
      rev_rdy[d]  = 1'b1;
      fwd_hold[d] = 1'b0;
      fwd_pkt[d]  = '0;
      rev_pkt[d]  = '0;
    end
    repeat (2) @(negedge clk);
    rst = 1'b0;

    // idle outputs after reset
    for (int d = 0; d < dirs_c; d++) begin
      assert (!mon[d].fwd.v && !mon[d].rev.v)
        else report_error($sformatf("valid high on port %0d after reset", d));
      assert (mon[d].fwd.ready_and_rev && mon[d].rev.ready_and_rev)
        else report_error($sformatf("input %0d not ready after reset", d));
    end
    fork
      receive(0);
      receive(1);
      receive(2);
      receive(3);
      receive(4);
    join_none

    // every input to every destination class on both networks
    for (int d = 0; d < dirs_c; d++) begin
      for (int t = 0; t < 10; t++) begin
        fork
          send_fwd(d, make_fwd(d, dest_x_c[t], dest_y_c[t]));
          send_rev(d, make_rev(d, dest_x_c[t], dest_y_c[t]));
        join
      end
      wait_drain("directed routes to drain");
    end

    // stall S so the W input FIFO fills behind the held packet
    fwd_hold[s_port_c] = 1'b1;
    held = make_fwd(w_port_c, 5, 7);
    send_fwd(w_port_c, held);
    send_fwd(w_port_c, make_fwd(w_port_c, 5, 7));
    assert (!mon[w_port_c].fwd.ready_and_rev) else report_error("full input FIFO still ready");
    fork
      send_fwd(w_port_c, make_fwd(w_port_c, 5, 7));
    join_none
    repeat (4) begin
      @(negedge clk);
      assert (mon[s_port_c].fwd.v && mon[s_port_c].fwd.packet == held)
        else report_error("stalled output packet changed");
    end
    fwd_hold[s_port_c] = 1'b0;
    wait_drain("stalled output to drain");

    // four inputs queue two packets each for P
    fwd_hold[p_port_c] = 1'b1;
    p_order_q.delete();
    fork
      repeat (2) send_fwd(1, make_fwd(1, 5, 5));
      repeat (2) send_fwd(2, make_fwd(2, 5, 5));
      repeat (2) send_fwd(3, make_fwd(3, 5, 5));
      repeat (2) send_fwd(4, make_fwd(4, 5, 5));
    join
    fwd_hold[p_port_c] = 1'b0;
    wait_drain("contended output to drain");
    assert (p_order_q.size() == 8) else report_error("contended output lost packets");
    order_mask = 0;
    for (int n = 0; n < 4; n++) begin
      order_mask = order_mask | (1 << p_order_q[n]);
    end
    assert (order_mask == 'h1e) else report_error("input served twice before round finished");

    // random traffic and back-pressure everywhere
    stall_en = 1'b1;
    fork
      random_port(0, 1'b0, 16);
      random_port(1, 1'b0, 16);
      random_port(2, 1'b0, 16);
      random_port(3, 1'b0, 16);
      random_port(4, 1'b0, 16);
      random_port(0, 1'b1, 16);
      random_port(1, 1'b1, 16);
      random_port(2, 1'b1, 16);
      random_port(3, 1'b1, 16);
      random_port(4, 1'b1, 16);
    join
    stall_en = 1'b0;
    wait_drain("random traffic to drain");

    // outputs stay idle once every expected packet has left
    repeat (4) begin
      @(negedge clk);
      for (int d = 0; d < dirs_c; d++) begin
        assert (!mon[d].fwd.v && !mon[d].rev.v)
          else report_error($sformatf("extra packet on port %0d after drain", d));
      end
    end

    $display("test passed");
    $finish;
  end

endmodule

// File: build.f
rtl/mesh_dir_pkg.sv
rtl/manycore_packet_pkg.sv
rtl/router_input_fifo.sv
rtl/router_route_decode.sv
rtl/router_output_arbiter.sv
rtl/mesh_router_buffered.sv
rtl/mesh_node.sv
testbench/mesh_node_assertions.sv
testbench/mesh_node_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the mesh node testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module mesh_node_tb \
  -Mdir obj_dir -o mesh_node_sim
build_status=$?
if [ "$build_status" -ne 0 ]; then
  echo "verilator build failed with status $build_status"
  exit "$build_status"
fi

./obj_dir/mesh_node_sim
run_status=$?
if [ "$run_status" -ne 0 ]; then
  echo "simulation failed with status $run_status"
  exit "$run_status"
fi
exit 0
